/* verif/cache_testdata.txt */
# op addr data dram: op is R read, W write, X reset; addr and data in hex
# data is the expected word for a read and the written word for a write; dram 1 if DRAM is used
R 00000090 a5ed 1
R 00000096 a5ee 0
R 000001a6 a576 1
R 000001a0 a575 0
R 000001a2 a574 0
R 000001a4 a577 0
R 000001a8 a571 0
R 000001aa a570 0
R 000001ac a573 0
R 000001ae a572 0
W 000001a4 1234 1
R 000001a4 1234 1
R 000001a2 a574 0
R 00000080 a5e5 1
R 00000100 a525 1
R 00000180 a565 1
R 00000200 a4a5 1
R 0000008c a5e3 0
R 00000284 a4e7 1
R 0000018a a560 0
R 00000100 a525 1
X 00000000 0000 0
R 00000090 a5ed 1
R 00000096 a5ee 0
W 00000300 beef 1
R 00000300 beef 1

/* cacheTop.f */
+incdir+include
hw/cachePkg.sv
hw/tagStore.sv
hw/dataStore.sv
hw/plruStore.sv
hw/cacheSequencer.sv
hw/cacheTop.sv
verif/cacheTop_checker.sv
verif/cacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator and run it.
# The exit status is nonzero when any check or assertion fails.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
	-f cacheTop.f \
	--top-module cacheTb \
	-o cacheTb

./obj_dir/cacheTb

/* verif/cacheTb.sv */
/*
 * Cache testbench
 * Runs the accesses of the test data file through the cache with a paced
 * DRAM model behind it, checking read data and DRAM use per access.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheTb import cachePkg::*;;

	logic Clock;
	logic Reset_L;
	cpuReq_t cpuReq;
	cpuRsp_t cpuRsp;
	memReq_t memReq;
	memRsp_t memRsp;

	logic [`DATA_W-1:0] memWords [logic [`ADDR_W-1:0]]; // DRAM words written so far
	int memTxns;                                     // DRAM transactions since time zero

	cacheTop i_cacheTop (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.cpuReq(cpuReq),
		.cpuRsp(cpuRsp),
		.memReq(memReq),
		.memRsp(memRsp)
	);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;                   // 8 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// DRAM model
	////////////////////////////////////////////////////////////////////////////
	// untouched words follow a pattern of the whole byte address
	function automatic logic [`DATA_W-1:0] initialWord(input logic [`ADDR_W-1:0] addr);
		return 16'((addr >> 1) ^ (addr >> 17)) ^ 16'hA5A5;
	endfunction

	function automatic logic [`DATA_W-1:0] readWord(input logic [`ADDR_W-1:0] addr);
		if (memWords.exists(addr)) begin
			return memWords[addr];
		end
		return initialWord(addr);
	endfunction

	initial begin : dramModel
		int pause;
		int beats;
		logic [`ADDR_W-1:0] baseAddr;
		memRsp = '0;
		memTxns = 0;
		void'($urandom(98));                         // one seed for all DRAM pacing
		forever begin
			@(posedge Clock);
			#1;
			if (Reset_L && memReq.sel) begin
				memTxns++;
				baseAddr = memReq.addr;              // line base for a fill
				beats = memReq.write ? 1 : `LINE_WORDS;
				for (int k = 0; k < beats; k++) begin
					pause = $urandom % 4;            // up to three idle cycles per ack
					repeat (pause) begin
						@(posedge Clock);
						#1;
					end
					if (memReq.write) begin
						memWords[baseAddr] = memReq.wrData;
					end else begin
						memRsp.rdData = readWord(baseAddr + 32'(2 * k));
					end
					memRsp.ack = 1'b1;
					@(posedge Clock);
					#1;
					memRsp.ack = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// error reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkData(input cpuRsp_t rsp, input logic [`DATA_W-1:0] expected,
			input logic [`ADDR_W-1:0] addr);
		if (rsp.rdData !== expected) begin
			stopOnError($sformatf("Fail at %0t: read of %h returned %h, expected %h",
				$time, addr, rsp.rdData, expected));
		end
	endtask

	task automatic checkMemUse(input bit used, input bit expected,
			input logic [`ADDR_W-1:0] addr);
		if (used != expected) begin
			stopOnError($sformatf("Fail at %0t: access to %h used DRAM %0d, expected %0d",
				$time, addr, used, expected));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// CPU driver
	////////////////////////////////////////////////////////////////////////////
	task automatic waitAck(input logic level);
		int cycles;
		cycles = 0;
		while (cpuRsp.ack !== level && cycles < 200) begin
			@(posedge Clock);
			#1;
			cycles++;
		end
		if (cpuRsp.ack !== level) begin
			stopOnError($sformatf("Timeout: cache ack did not reach %0d within 200 cycles",
				level));
		end
	endtask

	task automatic applyReset();
		@(posedge Clock);
		#1;
		Reset_L = 1'b0;
		repeat (3) @(posedge Clock);
		#1;
		Reset_L = 1'b1;                              // cache now invalidates its sets
	endtask

	task automatic doAccess(input bit write, input logic [`ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] data, input bit expectDram);
		int txnsBefore;
		@(posedge Clock);
		#1;
		txnsBefore = memTxns;
		cpuReq.write = write;
		cpuReq.addr = addr;
		cpuReq.wrData = data;
		cpuReq.strobe = 1'b1;
		waitAck(1'b1);
		if (!write) begin
			checkData(cpuRsp, data, addr);           // data column holds the expected word
		end
		checkMemUse(memTxns != txnsBefore, expectDram, addr);
		cpuReq.strobe = 1'b0;
		waitAck(1'b0);
		@(posedge Clock);                            // one quiet cycle before the next strobe
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test data reader
	////////////////////////////////////////////////////////////////////////////
	initial begin : mainFlow
		int fd;
		int fields;
		int dramFlag;
		int accessCount;
		string lineText;
		logic [7:0] op;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		Reset_L = 1'b0;
		cpuReq = '0;
		accessCount = 0;
		fd = $fopen("verif/cache_testdata.txt", "r");
		if (fd == 0) begin
			stopOnError("Could not open the test data file verif/cache_testdata.txt");
		end
		applyReset();
		while (!$feof(fd)) begin
			lineText = "";
			void'($fgets(lineText, fd));
			if (lineText.len() < 3 || lineText[0] == "#") begin
				continue;                            // blank and comment lines
			end
			fields = $sscanf(lineText, "%c %h %h %d", op, addr, data, dramFlag);
			if (fields != 4) begin
				stopOnError({"Malformed test data line: ", lineText});
			end
			if (op == "X") begin
				applyReset();
			end else if (op == "R" || op == "W") begin
				doAccess(op == "W", addr, data, dramFlag != 0);
				accessCount++;
			end else begin
				stopOnError({"Unknown operation in test data line: ", lineText});
			end
		end
		$fclose(fd);
		if (accessCount > 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			stopOnError("No accesses were found in the test data file");
		end
	end

endmodule

/* verif/cacheTop_checker.sv */
/*
 * Sequencer protocol checker
 * Concurrent assertions on the CPU and DRAM handshakes and on the store
 * write enables, bound into the cache sequencer.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheTop_checker import cachePkg::*; (
	input logic Clock,
	input logic Reset_L,
	input seqState_e state,
	input cpuReq_t cpuReq,
	input cpuRsp_t cpuRsp,
	input memReq_t memReq,
	input wayMask_t tagWe,
	input wayMask_t dataWe
);

	// a burst word lands in exactly one way
	assert property (@(posedge Clock) disable iff (!Reset_L) $onehot0(dataWe))
		else $error("data write enable names more than one way");

	// invalidation is the only time all ways are written together
	assert property (@(posedge Clock) disable iff (!Reset_L)
		state != Invalidate |-> $onehot0(tagWe))
		else $error("tag write enable names more than one way");

	assert property (@(posedge Clock) disable iff (!Reset_L) cpuRsp.ack |-> cpuReq.strobe)
		else $error("cache ack without a CPU strobe");

	assert property (@(posedge Clock) disable iff (!Reset_L)
		memReq.sel && memReq.write |-> cpuReq.strobe && cpuReq.write)
		else $error("DRAM write outside a CPU write");

	// also covers reset, since reset holds the sequencer in Invalidate
	assert property (@(posedge Clock) state == Invalidate |-> !cpuRsp.ack && !memReq.sel)
		else $error("bus activity while invalidating");

endmodule

bind cacheSequencer cacheTop_checker i_checker (
	.Clock(Clock),
	.Reset_L(Reset_L),
	.state(state),
	.cpuReq(cpuReq),
	.cpuRsp(cpuRsp),
	.memReq(memReq),
	.tagWe(tagWe),
	.dataWe(dataWe)
);

/* hw/cacheTop.sv */
/*
 * Four-way set-associative read cache
 * Sits between the CPU strobe/ack bus and the DRAM controller, joining the
 * sequencer to the tag, data and pseudo-LRU stores.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheTop import cachePkg::*; (
	input logic Clock,
	input logic Reset_L,
	input cpuReq_t cpuReq,
	output cpuRsp_t cpuRsp,
	output memReq_t memReq,
	input memRsp_t memRsp
);

	logic [IDX_W-1:0] index;                         // set being looked up, filled or cleared
	wayMask_t tagWe;                                 // tag and valid write per way
	logic validIn;                                   // valid bit value that goes with tagWe
	wayMask_t dataWe;                                // one fill word write per way
	logic [WORD_W-1:0] word;                         // word of the line being read or written
	logic lruWe;                                     // mark the hit way as most recently used
	wayMask_t hit;                                   // valid tag match per way
	logic [`DATA_W-1:0] hitData;                     // word from the way that hit
	logic [WAY_W-1:0] victim;                        // way the tree bits name for replacement

	cacheSequencer i_cacheSequencer (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.cpuReq(cpuReq),
		.memRsp(memRsp),
		.hit(hit),
		.hitData(hitData),
		.victim(victim),
		.cpuRsp(cpuRsp),
		.memReq(memReq),
		.index(index),
		.tagWe(tagWe),
		.validIn(validIn),
		.dataWe(dataWe),
		.word(word),
		.lruWe(lruWe)
	);

	tagStore i_tagStore (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.index(index),
		.tagWe(tagWe),
		.validIn(validIn),
		.tag(cpuReq.addr.tag),
		.hit(hit)
	);

	dataStore i_dataStore (
		.Clock(Clock),
		.index(index),
		.word(word),
		.dataWe(dataWe),
		.fillData(memRsp.rdData),                    // burst words go straight into the line
		.hit(hit),
		.readData(hitData)
	);

	// every way of a set is written at once only while invalidating
	plruStore i_plruStore (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.index(index),
		.lruWe(lruWe),
		.accessWay(hit),
		.clear(&tagWe),
		.victim(victim)
	);

endmodule

/* hw/cacheSequencer.sv */
/*
 * Cache sequencer
 * Clears every set after reset, then serves CPU reads from the stores,
 * fills a missing line from DRAM as an eight-word burst into the victim way
 * and passes writes through to DRAM, dropping any cached copy.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheSequencer import cachePkg::*; (
	input logic Clock,
	input logic Reset_L,
	input cpuReq_t cpuReq,
	input memRsp_t memRsp,
	input wayMask_t hit,
	input logic [`DATA_W-1:0] hitData,
	input logic [WAY_W-1:0] victim,
	output cpuRsp_t cpuRsp,
	output memReq_t memReq,
	output logic [IDX_W-1:0] index,
	output wayMask_t tagWe,
	output logic validIn,
	output wayMask_t dataWe,
	output logic [WORD_W-1:0] word,
	output logic lruWe
);

	seqState_e state;                                // current sequencer state
	seqState_e nextState;
	logic [IDX_W-1:0] setCnt;                        // steps through the sets while invalidating
	logic [WORD_W-1:0] wordCnt;                      // counts burst words as DRAM acks them
	logic [WAY_W-1:0] fillWay;                       // victim latched when the miss is seen
	wayMask_t fillMask;                              // one-hot form of fillWay
	logic anyHit;
	logic lastWord;                                  // eighth burst word is arriving now

	assign anyHit = |hit;
	assign fillMask = wayMask_t'(1) << fillWay;
	assign lastWord = memRsp.ack && (wordCnt == WORD_W'(`LINE_WORDS - 1));

	////////////////////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= Invalidate;                     // every reset starts by clearing the sets
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// set and word counters, victim latch
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			setCnt <= '0;
			wordCnt <= '0;
			fillWay <= '0;
		end else begin
			if (state == Invalidate) begin
				setCnt <= setCnt + 1'b1;             // wraps back to zero after the last set
			end
			if (state == Lookup) begin
				wordCnt <= '0;                       // every burst starts at word zero
			end else if (state == Fill && memRsp.ack) begin
				wordCnt <= wordCnt + 1'b1;
			end
			if (state == Lookup && !anyHit && !cpuReq.write) begin
				fillWay <= victim;                   // hold the victim for the whole burst
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState = state;
		index = cpuReq.addr.index;                   // stores follow the CPU address by default
		word = cpuReq.addr.word;
		tagWe = '0;
		validIn = 1'b0;
		dataWe = '0;
		lruWe = 1'b0;
		cpuRsp.ack = 1'b0;
		cpuRsp.rdData = hitData;                     // read data always comes from the hit way
		memReq.sel = 1'b0;
		memReq.write = 1'b0;
		memReq.addr = cpuReq.addr;
		memReq.wrData = cpuReq.wrData;

		case (state)
			Invalidate: begin
				index = setCnt;
				tagWe = '1;                          // zero tags and valid bits of all ways
				if (setCnt == IDX_W'(`SETS - 1)) begin
					nextState = Idle;
				end
			end
			Idle: begin
				if (cpuReq.strobe) begin
					nextState = Lookup;
				end
			end
			Lookup: begin
				if (cpuReq.write) begin
					tagWe = hit;                     // validIn stays low, so a hit way is dropped
					nextState = WriteThrough;
				end else if (anyHit) begin
					cpuRsp.ack = cpuReq.strobe;      // hit data is already on the mux
					lruWe = 1'b1;
					nextState = Respond;
				end else begin
					nextState = Fill;
				end
			end
			Fill: begin
				memReq.sel = 1'b1;
				memReq.addr.word = '0;               // burst always starts at the line base
				word = wordCnt;
				if (memRsp.ack) begin
					dataWe = fillMask;
				end
				if (lastWord) begin
					tagWe = fillMask;                // line becomes valid with its last word
					validIn = 1'b1;
					nextState = Lookup;              // look up again, which now hits
				end
			end
			WriteThrough: begin
				memReq.sel = 1'b1;
				memReq.write = 1'b1;
				if (memRsp.ack) begin
					nextState = Respond;
				end
			end
			Respond: begin
				cpuRsp.ack = cpuReq.strobe;          // hold ack until the CPU ends its cycle
				if (!cpuReq.strobe) begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = Invalidate;
			end
		endcase
	end

endmodule

/* hw/plruStore.sv */
/*
 * Pseudo-LRU store
 * Three tree bits per set that name the way to replace on a miss, updated
 * to point away from every way that is accessed.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module plruStore import cachePkg::*; (
	input logic Clock,
	input logic Reset_L,
	input logic [IDX_W-1:0] index,
	input logic lruWe,
	input wayMask_t accessWay,
	input logic clear,
	output logic [WAY_W-1:0] victim
);

	lru_t lruMem [`SETS];                            // tree bits for every set
	lru_t curLru;                                    // bits of the addressed set
	lru_t nextLru;                                   // bits after the access

	assign curLru = lruMem[index];

	// the half bit picks the pair, then that pair's own bit picks the way
	assign victim = curLru.pickHalf ? {1'b1, curLru.pick23} : {1'b0, curLru.pick01};

	always_comb begin
		nextLru = curLru;
		case (accessWay)
			4'b0001: begin
				nextLru.pickHalf = 1'b1;             // replace from ways 2/3 next
				nextLru.pick01 = 1'b1;
			end
			4'b0010: begin
				nextLru.pickHalf = 1'b1;
				nextLru.pick01 = 1'b0;
			end
			4'b0100: begin
				nextLru.pickHalf = 1'b0;             // replace from ways 0/1 next
				nextLru.pick23 = 1'b1;
			end
			4'b1000: begin
				nextLru.pickHalf = 1'b0;
				nextLru.pick23 = 1'b0;
			end
			default: begin
				nextLru = curLru;                    // no access, keep the bits
			end
		endcase
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < `SETS; s++) begin
				lruMem[s] <= '0;
			end
		end else if (clear) begin
			lruMem[index] <= '0;                     // invalidation starts each set at way 0
		end else if (lruWe) begin
			lruMem[index] <= nextLru;
		end
	end

endmodule

/* hw/dataStore.sv */
/*
 * Data store
 * Eight words per line for each way and set. Burst words are written into
 * one way at a time, and reads return the word of the way that hit.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module dataStore import cachePkg::*; (
	input logic Clock,
	input logic [IDX_W-1:0] index,
	input logic [WORD_W-1:0] word,
	input wayMask_t dataWe,
	input logic [`DATA_W-1:0] fillData,
	input wayMask_t hit,
	output logic [`DATA_W-1:0] readData
);

	logic [`DATA_W-1:0] lineMem [`WAYS][`SETS][`LINE_WORDS];

	always_ff @(posedge Clock) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (dataWe[w]) begin
				lineMem[w][index][word] <= fillData; // one burst word per DRAM ack
			end
		end
	end

	// hit is one-hot or zero, so an OR of the gated ways acts as the mux
	always_comb begin
		readData = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (hit[w]) begin
				readData = readData | lineMem[w][index][word];
			end
		end
	end

endmodule

/* hw/tagStore.sv */
/*
 * Tag store
 * Tag and valid bit for every set and way, with the tag compare that
 * produces the per-way hit mask for the addressed set.
 */

`timescale 1ns/100ps
`include "cache_settings.svh"

module tagStore import cachePkg::*; (
	input logic Clock,
	input logic Reset_L,
	input logic [IDX_W-1:0] index,
	input wayMask_t tagWe,
	input logic validIn,
	input logic [TAG_W-1:0] tag,
	output wayMask_t hit
);

	logic [TAG_W-1:0] tagMem [`WAYS][`SETS];         // stored tag per way and set
	wayMask_t validMem [`SETS];                      // valid bits of one set as a way mask
	logic [TAG_W-1:0] tagIn;

	// invalidation and write hits store a zero tag
	assign tagIn = validIn ? tag : '0;

	always_ff @(posedge Clock) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (tagWe[w]) begin
				tagMem[w][index] <= tagIn;
			end
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int s = 0; s < `SETS; s++) begin
				validMem[s] <= '0;
			end
		end else begin
			for (int w = 0; w < `WAYS; w++) begin
				if (tagWe[w]) begin
					validMem[index][w] <= validIn;   // same write enable as the tag
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// hit compare across the ways of the addressed set
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int w = 0; w < `WAYS; w++) begin
			hit[w] = validMem[index][w] && (tagMem[w][index] == tag);
		end
	end

endmodule

/* hw/cachePkg.sv */
/*
 * Cache types
 * Address split, CPU and DRAM bus structs, way mask, tree pseudo-LRU bits
 * and the sequencer state encoding.
 */

`include "cache_settings.svh"

package cachePkg;

	localparam int IDX_W = $clog2(`SETS);            // 3 index bits for 8 sets
	localparam int WORD_W = $clog2(`LINE_WORDS);     // 3 bits pick a word in the line
	localparam int WAY_W = $clog2(`WAYS);            // 2 bits name a single way
	localparam int TAG_W = `ADDR_W - IDX_W - WORD_W - 1; // what is left is the 25-bit tag

	typedef struct packed {
		logic [TAG_W-1:0] tag;                       // compared against every way of the set
		logic [IDX_W-1:0] index;                     // selects the set
		logic [WORD_W-1:0] word;                     // word inside the eight-word line
		logic byteSel;                               // always zero since all accesses are words
	} cacheAddr_t;

	typedef logic [`WAYS-1:0] wayMask_t;             // one bit per way, for hits and write enables

	typedef struct packed {
		logic strobe;                                // held by the CPU until after ack
		logic write;                                 // high for a write, low for a read
		cacheAddr_t addr;
		logic [`DATA_W-1:0] wrData;
	} cpuReq_t;

	typedef struct packed {
		logic ack;                                   // held until the CPU drops strobe
		logic [`DATA_W-1:0] rdData;
	} cpuRsp_t;

	typedef struct packed {
		logic sel;                                   // held until the last expected ack
		logic write;
		cacheAddr_t addr;                            // line base address during a fill
		logic [`DATA_W-1:0] wrData;
	} memReq_t;

	typedef struct packed {
		logic ack;                                   // one per word, may come after idle cycles
		logic [`DATA_W-1:0] rdData;
	} memRsp_t;

	typedef enum logic [2:0] {
		Invalidate,
		Idle,
		Lookup,
		Fill,
		Respond,
		WriteThrough
	} seqState_e;

	// each bit points at the side to be replaced next
	typedef struct packed {
		logic pick23;                                // bit 2, 0 means way 2 and 1 means way 3
		logic pick01;                                // bit 1, 0 means way 0 and 1 means way 1
		logic pickHalf;                              // bit 0, 0 means ways 0/1 and 1 means ways 2/3
	} lru_t;

endpackage

/* include/cache_settings.svh */
/*
 * Cache geometry and bus widths
 * Shared sizes for the four-way read cache between the 16-bit CPU and DRAM.
 * The address split in the package is derived from these values.
 */

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////////////////////
`define ADDR_W 32                              // CPU and DRAM byte address width
`define DATA_W 16                              // every access is one 16-bit word

////////////////////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////////////////////
`define WAYS 4                                 // ways per set, one tag compare each
`define SETS 8                                 // sets, selected by the index bits
`define LINE_WORDS 8                           // words fetched by one burst fill

`endif
